// ==== hw/mant_div_pipe.sv ====
`timescale 1ns/10ps

module mant_div_pipe #(
   parameter int N  = posit_div_pkg::POSIT_N_DEFAULT,
   parameter int ES = posit_div_pkg::POSIT_ES_DEFAULT
) (
   input  logic                                               clk,
   input  logic                                               rst_n_i,
   input  logic                                               valid_i,
   input  logic                                               sign_i,
   input  logic signed [posit_div_pkg::scale_width(N, ES)-1:0] scale_i,
   input  logic [posit_div_pkg::mant_width(N, ES)-1:0]        dividend_mant_i,
   input  logic [posit_div_pkg::mant_width(N, ES)-1:0]        divisor_mant_i,
   input  logic                                               nar_i,
   input  logic                                               zero_i,
   output logic                                               valid_o,
   output logic                                               sign_o,
   output logic signed [posit_div_pkg::scale_width(N, ES)-1:0] scale_o,
   output logic [posit_div_pkg::quot_width(N, ES)-1:0]        quot_o,
   output logic                                               sticky_o,
   output logic                                               nar_o,
   output logic                                               zero_o
);
   import posit_div_pkg::*;

   localparam int MW = mant_width(N, ES);
   localparam int QW = quot_width(N, ES);
   localparam int SW = scale_width(N, ES);

   // one register set per quotient bit
   logic                 valid_q [QW];
   logic                 sign_q  [QW];
   logic signed [SW-1:0] scale_q [QW];
   logic [QW-1:0]        quot_q  [QW];
   logic [MW:0]          rem_q   [QW];             // partial remainder, already doubled
   logic [MW-1:0]        dvsr_q  [QW];
   logic                 nar_q   [QW];
   logic                 zero_q  [QW];

   //////////////////////////////////////////////////
   // restoring divide stages
   //////////////////////////////////////////////////

   for (genvar s = 0; s < QW; s++) begin : g_stage
      localparam int P = (s == 0) ? 0 : s - 1;     // previous stage index

      logic [MW:0]   rem_in;
      logic [MW-1:0] dvsr_in;
      logic [QW-1:0] quot_in;
      logic          q_bit;
      logic [MW:0]   rem_sub;

      assign rem_in  = (s == 0) ? {1'b0, dividend_mant_i} : rem_q[P];
      assign dvsr_in = (s == 0) ? divisor_mant_i : dvsr_q[P];
      assign quot_in = (s == 0) ? '0 : quot_q[P];

      assign q_bit   = rem_in >= {1'b0, dvsr_in};              // trial subtract fits
      assign rem_sub = q_bit ? rem_in - {1'b0, dvsr_in} : rem_in;

      always_ff @(posedge clk) begin
         if (!rst_n_i) begin
            valid_q[s] <= 1'b0;
         end else begin
            valid_q[s] <= (s == 0) ? valid_i : valid_q[P];
         end
      end

      always_ff @(posedge clk) begin
         rem_q[s]   <= {rem_sub[MW-1:0], 1'b0};   // rem_sub is below the divisor
         dvsr_q[s]  <= dvsr_in;
         quot_q[s]  <= {quot_in[QW-2:0], q_bit};
         sign_q[s]  <= (s == 0) ? sign_i : sign_q[P];
         scale_q[s] <= (s == 0) ? scale_i : scale_q[P];
         nar_q[s]   <= (s == 0) ? nar_i : nar_q[P];
         zero_q[s]  <= (s == 0) ? zero_i : zero_q[P];
      end
   end

   //////////////////////////////////////////////////
   // last stage to the encoder
   //////////////////////////////////////////////////

   assign valid_o  = valid_q[QW-1];
   assign sign_o   = sign_q[QW-1];
   assign scale_o  = scale_q[QW-1];
   assign quot_o   = quot_q[QW-1];
   assign sticky_o = |rem_q[QW-1];                 // bits beyond the last quotient bit
   assign nar_o    = nar_q[QW-1];
   assign zero_o   = zero_q[QW-1];

   // an unknown strobe here would break the done count at the top level
   a_valid_known : assert property (
      @(posedge clk) disable iff (!rst_n_i) !$isunknown(valid_o)
   );

endmodule

// ==== hw/posit_decode.sv ====
`timescale 1ns/10ps

module posit_decode #(
   parameter int N  = posit_div_pkg::POSIT_N_DEFAULT,
   parameter int ES = posit_div_pkg::POSIT_ES_DEFAULT
) (
   input  logic                                               clk,
   input  logic                                               rst_n_i,
   input  logic                                               start_i,
   input  logic [N-1:0]                                       dividend_i,
   input  logic [N-1:0]                                       divisor_i,
   output logic                                               valid_o,
   output logic                                               sign_o,
   output logic signed [posit_div_pkg::scale_width(N, ES)-1:0] scale_o,
   output logic [posit_div_pkg::mant_width(N, ES)-1:0]        dividend_mant_o,
   output logic [posit_div_pkg::mant_width(N, ES)-1:0]        divisor_mant_o,
   output logic                                               nar_o,
   output logic                                               zero_o
);
   import posit_div_pkg::*;

   localparam int MW = mant_width(N, ES);
   localparam int SW = scale_width(N, ES);
   localparam int RW = $clog2(N);                   // holds a run of up to N-1 bits
   localparam logic [N-1:0] NAR_PAT = {1'b1, {(N - 1){1'b0}}};

   logic [N-1:0]         op    [2];                 // 0 is the dividend, 1 the divisor
   logic [N-1:0]         mag   [2];
   logic [RW-1:0]        run   [2];
   logic [N-2:0]         rest  [2];                 // exponent and fraction, left aligned
   logic signed [SW-1:0] k     [2];
   logic signed [SW-1:0] scale [2];
   logic [MW-1:0]        mant  [2];
   logic                 nar_any;

   // regime run length, the leading one of the (possibly inverted) body ends it
   function automatic logic [RW-1:0] run_length(input logic [N-2:0] body);
      logic [N-2:0]  inv;
      logic [RW-1:0] len;
      logic          hit;
      inv = body[N-2] ? ~body : body;
      len = RW'(N - 1);                             // no terminator in the word
      hit = 1'b0;
      for (int b = N - 2; b >= 0; b--) begin
         if (!hit && inv[b]) begin
            len = RW'(N - 2 - b);
            hit = 1'b1;
         end
      end
      return len;
   endfunction

   assign op[0] = dividend_i;
   assign op[1] = divisor_i;

   //////////////////////////////////////////////////
   // field extraction for both operands
   //////////////////////////////////////////////////

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         mag[i]  = op[i][N-1] ? -op[i] : op[i];            // two's complement magnitude
         run[i]  = run_length(mag[i][N-2:0]);
         rest[i] = mag[i][N-2:0] << (run[i] + 1);          // drop regime and terminator
         k[i]    = mag[i][N-2] ? SW'(run[i]) - SW'(1) : -SW'(run[i]);
         scale[i] = (k[i] <<< ES) + SW'(rest[i][N-2 -: ES]);
         mant[i]  = {1'b1, rest[i][N-2-ES:0]};             // hidden bit on top
      end
   end

   assign nar_any = (dividend_i == NAR_PAT) || (divisor_i == NAR_PAT) || (divisor_i == '0);

   //////////////////////////////////////////////////
   // first pipeline register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= start_i;
      end
   end

   always_ff @(posedge clk) begin
      sign_o          <= dividend_i[N-1] ^ divisor_i[N-1];
      scale_o         <= scale[0] - scale[1];
      dividend_mant_o <= mant[0];
      divisor_mant_o  <= mant[1];
      nar_o           <= nar_any;
      zero_o          <= (dividend_i == '0) && !nar_any;    // 0 / 0 stays NaR
   end

   // the flags travel to the encoder, which relies on at most one of them
   a_flags_exclusive : assert property (
      @(posedge clk) disable iff (!rst_n_i) valid_o |-> !(nar_o && zero_o)
   );

endmodule

// ==== hw/posit_div.sv ====
`timescale 1ns/10ps

module posit_div #(
   parameter int N  = posit_div_pkg::POSIT_N_DEFAULT,
   parameter int ES = posit_div_pkg::POSIT_ES_DEFAULT
) (
   input  logic         clk,
   input  logic         rst_n_i,
   input  logic         start_i,
   input  logic [N-1:0] dividend_i,
   input  logic [N-1:0] divisor_i,
   output logic [N-1:0] quotient_o,
   output logic         done_o,
   output logic         nar_o,
   output logic         zero_o
);
   import posit_div_pkg::*;

   localparam int MW = mant_width(N, ES);
   localparam int QW = quot_width(N, ES);
   localparam int SW = scale_width(N, ES);

   //////////////////////////////////////////////////
   // decode to divider
   //////////////////////////////////////////////////

   logic                 dec_valid;
   logic                 dec_sign;
   logic signed [SW-1:0] dec_scale;
   logic [MW-1:0]        dec_dividend_mant;
   logic [MW-1:0]        dec_divisor_mant;
   logic                 dec_nar;
   logic                 dec_zero;

   // divider to encoder
   logic                 div_valid;
   logic                 div_sign;
   logic signed [SW-1:0] div_scale;
   logic [QW-1:0]        div_quot;
   logic                 div_sticky;
   logic                 div_nar;
   logic                 div_zero;

   posit_decode #(.N(N), .ES(ES)) u_decode (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .start_i         (start_i),
      .dividend_i      (dividend_i),
      .divisor_i       (divisor_i),
      .valid_o         (dec_valid),
      .sign_o          (dec_sign),
      .scale_o         (dec_scale),
      .dividend_mant_o (dec_dividend_mant),
      .divisor_mant_o  (dec_divisor_mant),
      .nar_o           (dec_nar),
      .zero_o          (dec_zero)
   );

   mant_div_pipe #(.N(N), .ES(ES)) u_div (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .valid_i         (dec_valid),
      .sign_i          (dec_sign),
      .scale_i         (dec_scale),
      .dividend_mant_i (dec_dividend_mant),
      .divisor_mant_i  (dec_divisor_mant),
      .nar_i           (dec_nar),
      .zero_i          (dec_zero),
      .valid_o         (div_valid),
      .sign_o          (div_sign),
      .scale_o         (div_scale),
      .quot_o          (div_quot),
      .sticky_o        (div_sticky),
      .nar_o           (div_nar),
      .zero_o          (div_zero)
   );

   posit_encode #(.N(N), .ES(ES)) u_encode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .valid_i    (div_valid),
      .sign_i     (div_sign),
      .scale_i    (div_scale),
      .quot_i     (div_quot),
      .sticky_i   (div_sticky),
      .nar_i      (div_nar),
      .zero_i     (div_zero),
      .quotient_o (quotient_o),
      .done_o     (done_o),
      .nar_o      (nar_o),
      .zero_o     (zero_o)
   );

endmodule

// ==== hw/posit_div_pkg.sv ====
package posit_div_pkg;

   //////////////////////////////////////////////////
   // default posit format
   //////////////////////////////////////////////////

   localparam int POSIT_N_DEFAULT  = 32;   // total posit width
   localparam int POSIT_ES_DEFAULT = 6;    // exponent field width

   //////////////////////////////////////////////////
   // derived widths
   //////////////////////////////////////////////////

   // hidden bit plus every fraction bit a posit can carry
   function automatic int mant_width(input int n, input int es);
      return n - es;
   endfunction

   // one extra bit for normalisation and one guard bit
   function automatic int quot_width(input int n, input int es);
      return mant_width(n, es) + 2;
   endfunction

   // signed scale difference of two posits, largest regime on both sides
   function automatic int scale_width(input int n, input int es);
      return $clog2(2 * (n - 1) * (2 ** es) + 2) + 1;
   endfunction

   // decode, one cycle per quotient bit, two encode stages
   function automatic int div_latency(input int n, input int es);
      return quot_width(n, es) + 3;
   endfunction

endpackage

// ==== hw/posit_encode.sv ====
`timescale 1ns/10ps

module posit_encode #(
   parameter int N  = posit_div_pkg::POSIT_N_DEFAULT,
   parameter int ES = posit_div_pkg::POSIT_ES_DEFAULT
) (
   input  logic                                               clk,
   input  logic                                               rst_n_i,
   input  logic                                               valid_i,
   input  logic                                               sign_i,
   input  logic signed [posit_div_pkg::scale_width(N, ES)-1:0] scale_i,
   input  logic [posit_div_pkg::quot_width(N, ES)-1:0]        quot_i,
   input  logic                                               sticky_i,
   input  logic                                               nar_i,
   input  logic                                               zero_i,
   output logic [N-1:0]                                       quotient_o,
   output logic                                               done_o,
   output logic                                               nar_o,
   output logic                                               zero_o
);
   import posit_div_pkg::*;

   localparam int QW = quot_width(N, ES);
   localparam int SW = scale_width(N, ES);
   localparam int RW = $clog2(N);
   localparam int VW = N + ES + QW - 1;            // regime, exponent, fraction, spill room
   localparam logic signed [SW-1:0] K_MAX = SW'(N - 2);
   localparam logic signed [SW-1:0] K_MIN = -K_MAX;
   localparam logic [N-1:0] NAR_PAT = {1'b1, {(N - 1){1'b0}}};

   logic [QW-1:0]        quot_n;
   logic signed [SW-1:0] scale_n;
   logic signed [SW-1:0] k_raw;
   logic signed [SW-1:0] k_clamp;
   logic [ES-1:0]        exp_clamp;
   logic [QW-2:0]        frac_clamp;
   logic                 sticky_clamp;

   logic                 s1_valid;
   logic                 s1_sign;
   logic signed [SW-1:0] s1_k;
   logic [ES-1:0]        s1_exp;
   logic [QW-2:0]        s1_frac;
   logic                 s1_sticky;
   logic                 s1_nar;
   logic                 s1_zero;

   logic                 kneg;
   logic [RW-1:0]        run_len;
   logic [VW-1:0]        base;
   logic [VW-1:0]        shifted;
   logic [N-2:0]         body;
   logic                 guard_b;
   logic                 round_b;
   logic                 sticky_b;
   logic                 round_up;
   logic [N-2:0]         rounded;
   logic [N-1:0]         result;

   //////////////////////////////////////////////////
   // stage 1  normalise and split the scale
   //////////////////////////////////////////////////

   always_comb begin
      if (quot_i[QW-1]) begin
         quot_n  = quot_i;
         scale_n = scale_i;
      end else begin
         quot_n  = {quot_i[QW-2:0], 1'b0};          // quotient was below one
         scale_n = scale_i - SW'(1);
      end
      k_raw        = scale_n >>> ES;                // floor division by 2^es
      k_clamp      = k_raw;
      exp_clamp    = scale_n[ES-1:0];
      frac_clamp   = quot_n[QW-2:0];
      sticky_clamp = sticky_i;
      if (k_raw > K_MAX) begin
         k_clamp = K_MAX;                           // all ones body, guard bit clear
      end else if (k_raw < K_MIN) begin
         k_clamp      = K_MIN;                      // lands exactly on minpos
         exp_clamp    = '0;
         frac_clamp   = '0;
         sticky_clamp = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= valid_i;
      end
   end

   always_ff @(posedge clk) begin
      s1_sign   <= sign_i;
      s1_k      <= k_clamp;
      s1_exp    <= exp_clamp;
      s1_frac   <= frac_clamp;
      s1_sticky <= sticky_clamp;
      s1_nar    <= nar_i;
      s1_zero   <= zero_i;
   end

   //////////////////////////////////////////////////
   // stage 2  pack, round, restore sign
   //////////////////////////////////////////////////

   always_comb begin
      kneg    = s1_k[SW-1];
      run_len = kneg ? RW'(-s1_k) : RW'(s1_k + 1);
      base    = {kneg, s1_exp, s1_frac, {(N - 1){1'b0}}};  // terminator leads
      shifted = base >> run_len;
      if (!kneg) begin
         shifted = shifted | ~({VW{1'b1}} >> run_len);     // run of ones for k >= 0
      end
      body     = shifted[VW-1 -: N-1];
      guard_b  = shifted[VW-N];
      round_b  = shifted[VW-N-1];
      sticky_b = |shifted[VW-N-2:0] | s1_sticky;
      round_up = guard_b & (round_b | sticky_b | body[0]);  // nearest, ties to even
      rounded  = (round_up && !(&body)) ? body + 1'b1 : body;  // stop at maxpos
      result   = s1_sign ? -{1'b0, rounded} : {1'b0, rounded};
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         done_o <= 1'b0;
      end else begin
         done_o <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      quotient_o <= s1_nar ? NAR_PAT : (s1_zero ? '0 : result);
      nar_o      <= s1_nar;
      zero_o     <= s1_zero;
   end

   // saturation keeps every finite quotient off the NaR code
   a_nar_only_flagged : assert property (
      @(posedge clk) disable iff (!rst_n_i) (done_o && quotient_o == NAR_PAT) |-> nar_o
   );

endmodule

// ==== posit_div.f ====
+incdir+tests
hw/posit_div_pkg.sv
hw/posit_decode.sv
hw/mant_div_pipe.sv
hw/posit_encode.sv
hw/posit_div.sv
tests/tb_clock_gen.sv
tests/posit_div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the posit divider testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f posit_div.f \
   --top-module posit_div_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vposit_div_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Errors found" "$LOG"; then
   echo "simulation failed"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi
echo "simulation passed"
exit 0

// ==== tests/posit_div_ref.svh ====
`ifndef POSIT_DIV_REF_SVH
`define POSIT_DIV_REF_SVH

// works on the N and ES localparams of the including module

// sign dropped, scale = k * 2^es + e, significand 1.f with N-1 fraction bits
function automatic void ref_decode(input logic [N-1:0] p, output int scale,
                                   output logic [63:0] sig);
   logic [N-1:0] mag;
   logic         r0;
   int           i;
   int           m;
   int           k;
   int           e;
   mag = p[N-1] ? -p : p;
   r0  = mag[N-2];
   i   = N - 2;
   m   = 0;
   while (i >= 0 && mag[i] == r0) begin
      m = m + 1;
      i = i - 1;
   end
   k = r0 ? m - 1 : -m;
   i = i - 1;                                      // skip the terminator
   e = 0;
   for (int j = 0; j < ES; j++) begin
      e = 2 * e + ((i >= 0 && mag[i]) ? 1 : 0);    // missing exponent bits read as 0
      i = i - 1;
   end
   sig = 64'd1;
   for (int j = 0; j < N - 1; j++) begin
      sig = {sig[62:0], (i >= 0) ? mag[i] : 1'b0};
      i = i - 1;
   end
   scale = k * (1 << ES) + e;
endfunction

// value (1.frac) * 2^scale, frac holds nfrac bits, sticky marks a lost remainder
function automatic logic [N-1:0] ref_encode(input logic sign, input int scale,
                                            input logic [63:0] frac, input int nfrac,
                                            input logic sticky);
   logic [127:0] bits;
   logic [N-2:0] body;
   logic [N-1:0] res;
   logic         guard;
   logic         rest;
   int           k;
   int           e;
   int           pos;
   if (scale >= 0) begin
      k = scale / (1 << ES);
   end else begin
      k = -((-scale + (1 << ES) - 1) / (1 << ES));  // floor for negative scales
   end
   e = scale - k * (1 << ES);
   if (k > N - 2) begin
      body = '1;                                   // beyond maxpos
   end else if (k < 2 - N) begin
      body = (N - 1)'(1);                          // below minpos
   end else begin
      bits = '0;
      pos  = 127;
      if (k >= 0) begin
         for (int j = 0; j <= k; j++) begin
            bits[pos] = 1'b1;
            pos = pos - 1;
         end
         pos = pos - 1;                            // terminating zero
      end else begin
         pos = pos + k;
         bits[pos] = 1'b1;
         pos = pos - 1;
      end
      for (int j = ES - 1; j >= 0; j--) begin
         bits[pos] = e[j];
         pos = pos - 1;
      end
      for (int j = nfrac - 1; j >= 0; j--) begin
         bits[pos] = frac[j];
         pos = pos - 1;
      end
      body  = bits[127 -: N-1];
      guard = bits[127 - (N - 1)];
      rest  = (|bits[127-N:0]) | sticky;
      // nearest even, never past maxpos
      if (guard && (rest || body[0]) && body != '1) begin
         body = body + 1'b1;
      end
   end
   res = {1'b0, body};
   if (sign) begin
      res = -res;
   end
   return res;
endfunction

function automatic void posit_ref_div(input logic [N-1:0] a, input logic [N-1:0] b,
                                      output logic [N-1:0] q, output logic nar,
                                      output logic zero);
   localparam int QB = 62 - N;                     // extra quotient bits, fits 64 bits
   localparam logic [N-1:0] NAR = {1'b1, {(N - 1){1'b0}}};
   int          sa;
   int          sb;
   int          sc;
   int          nf;
   logic [63:0] ma;
   logic [63:0] mb;
   logic [63:0] quo;
   logic [63:0] rem;
   nar  = (a == NAR) || (b == NAR) || (b == '0);
   zero = !nar && (a == '0);
   if (nar) begin
      q = NAR;
   end else if (zero) begin
      q = '0;
   end else begin
      ref_decode(a, sa, ma);
      ref_decode(b, sb, mb);
      quo = (ma << QB) / mb;
      rem = (ma << QB) % mb;
      sc  = sa - sb;
      if (quo[QB]) begin
         nf = QB;
      end else begin
         nf = QB - 1;                              // ratio below one
         sc = sc - 1;
      end
      q = ref_encode(a[N-1] ^ b[N-1], sc, quo, nf, rem != 0);
   end
endfunction

`endif

// ==== tests/posit_div_tb.sv ====
`timescale 1ns/10ps

module posit_div_tb;
   import posit_div_pkg::*;

   localparam int N            = POSIT_N_DEFAULT;
   localparam int ES           = POSIT_ES_DEFAULT;
   localparam int LAT          = div_latency(N, ES);
   localparam int RESET_CYCLES = 10;
   localparam int N_DIRECTED   = 30;
   localparam int N_RANDOM     = 300;
   localparam int MAX_GAP      = 3;
   localparam logic [31:0] RAND_SEED = 32'hb91c;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_DIRECTED
                                 + N_RANDOM * (MAX_GAP + 1) + LAT + 20;

   // {dividend, divisor}
   localparam logic [63:0] DIRECTED [N_DIRECTED] = '{
      64'h40000000_40000000, 64'h41000000_40800000, 64'h40800000_41000000,  // exact
      64'h40000000_3F800000, 64'hC0000000_40000000, 64'h40000000_C0000000,
      64'hBF800000_C0000000, 64'h40C00000_40400000, 64'h60000000_40000000,
      64'h40000000_60000000,
      64'h80000000_40000000, 64'h40000000_80000000, 64'h40000000_00000000,  // specials
      64'h00000000_00000000, 64'h00000000_40800000, 64'h00000000_80000000,
      64'hC0000000_00000000, 64'h00000000_BF800000,
      64'h40000000_40C00000, 64'h40800000_40C00000, 64'h40000000_41600000,  // rounding
      64'h40000001_20000000, 64'h40000003_20000000, 64'h40000001_40000002,
      64'hC0000003_20000000,
      64'h7FFFFFFF_00000001, 64'h00000001_7FFFFFFF, 64'h7FFFFFFF_3F800000,  // saturation
      64'h00000001_40800000, 64'h80000001_00000001
   };

   logic         clk;
   logic         rst_n_i;
   logic         start_i;
   logic [N-1:0] dividend_i;
   logic [N-1:0] divisor_i;
   logic [N-1:0] quotient_o;
   logic         done_o;
   logic         nar_o;
   logic         zero_o;

   int             cyc = 0;
   logic [N+1:0]   exp_q [$];                      // {nar, zero, quotient}
   int             due_q [$];
   logic [2*N-1:0] op_q  [$];
   logic [N+1:0]   exp_word;
   logic [2*N-1:0] op_pair;
   int             due_cycle;

   `include "posit_div_ref.svh"

   tb_clock_gen #(.PERIOD_NS(4.0)) u_clk (.clk(clk));

   posit_div #(.N(N), .ES(ES)) UUT (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .start_i    (start_i),
      .dividend_i (dividend_i),
      .divisor_i  (divisor_i),
      .quotient_o (quotient_o),
      .done_o     (done_o),
      .nar_o      (nar_o),
      .zero_o     (zero_o)
   );

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("CHECK FAILED at %0t ns: %s, expected %h, got %h",
                  $time, what, expected, actual);
         $display("Errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   // a few hand encoded quotients keep the reference honest
   task automatic check_reference();
      logic [N-1:0] q;
      logic         nar;
      logic         zero;
      posit_ref_div(32'h41000000, 32'h40800000, q, nar, zero);
      check_equal(64'(q), 64'h40800000, "reference 4 / 2");
      posit_ref_div(32'h40000000, 32'hC0000000, q, nar, zero);
      check_equal(64'(q), 64'hC0000000, "reference 1 / -1");
      posit_ref_div(32'h40000000, 32'h40C00000, q, nar, zero);
      check_equal(64'(q), 64'h3F2AAAAB, "reference 1 / 3");
      posit_ref_div(32'h7FFFFFFF, 32'h00000001, q, nar, zero);
      check_equal(64'(q), 64'h7FFFFFFF, "reference maxpos / minpos");
      posit_ref_div(32'h00000000, 32'h40800000, q, nar, zero);
      check_equal(64'({nar, zero}), 64'd1, "reference 0 / 2 flags");
      posit_ref_div(32'h40000000, 32'h00000000, q, nar, zero);
      check_equal(64'({nar, zero}), 64'd2, "reference 1 / 0 flags");
   endtask

   task automatic drive_op(input logic [N-1:0] a, input logic [N-1:0] b);
      logic [N-1:0] q;
      logic         nar;
      logic         zero;
      @(posedge clk);
      #1;
      posit_ref_div(a, b, q, nar, zero);
      exp_q.push_back({nar, zero, q});
      due_q.push_back(cyc + LAT);                  // seen LAT cycles after this drive cycle
      op_q.push_back({a, b});
      start_i    = 1'b1;
      dividend_i = a;
      divisor_i  = b;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      start_i    = 1'b0;
      dividend_i = N'($urandom);                   // junk data must not produce results
      divisor_i  = N'($urandom);
   endtask

   //////////////////////////////////////////////////
   // cycle count and timeout
   //////////////////////////////////////////////////

   always @(posedge clk) begin
      cyc = cyc + 1;
      if (cyc > TIMEOUT_CYCLES) begin
         $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
         $display("Errors found");
         $fatal(1, "timeout");
      end
   end

   // scoreboard samples at the falling edge where outputs are settled
   always @(negedge clk) begin
      if (rst_n_i && done_o) begin
         if (exp_q.size() == 0) begin
            $display("done_o pulsed at %0t ns with no operation outstanding", $time);
            $display("Errors found");
            $fatal(1, "unexpected done");
         end else begin
            exp_word  = exp_q.pop_front();
            due_cycle = due_q.pop_front();
            op_pair   = op_q.pop_front();
            check_equal(64'(quotient_o), 64'(exp_word[N-1:0]),
                        $sformatf("quotient of %h / %h", op_pair[2*N-1 -: N], op_pair[N-1:0]));
            check_equal(64'(nar_o), 64'(exp_word[N+1]), "nar_o");
            check_equal(64'(zero_o), 64'(exp_word[N]), "zero_o");
            check_equal(64'(cyc), 64'(due_cycle), "done_o cycle");
         end
      end
   end

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   initial begin
      void'($urandom(RAND_SEED));
      rst_n_i    = 1'b0;
      start_i    = 1'b0;
      dividend_i = '0;
      divisor_i  = '0;
      check_reference();
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n_i = 1'b1;

      for (int i = 0; i < N_DIRECTED; i++) begin
         drive_op(DIRECTED[i][2*N-1 -: N], DIRECTED[i][N-1:0]);
      end
      idle_cycle();

      // back to back starts mixed with short gaps
      for (int i = 0; i < N_RANDOM; i++) begin
         if ($urandom % 4 == 0) begin
            repeat ($urandom % MAX_GAP + 1) idle_cycle();
         end
         drive_op(N'($urandom), N'($urandom));
      end
      idle_cycle();

      repeat (LAT + 5) @(posedge clk);
      if (exp_q.size() != 0) begin
         $display("%0d results never arrived on done_o", exp_q.size());
         $display("Errors found");
         $fatal(1, "missing results");
      end else begin
         $display("No errors");
         $finish;
      end
   end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter real PERIOD_NS = 4.0
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;   // free running, starts low
   end

endmodule
